// ==== hdl/fpu_pkg.sv ====
package fpu_pkg;

  localparam int FLEN       = 64;
  localparam int XLEN       = 64;
  localparam int NUM_FREGS  = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;
  localparam int FRM_W      = 3;
  localparam int FFLAGS_W   = 5;

  localparam logic [6:0] opcode_fp = 7'b1010011;

  // Compared against funct7[6:2]
  localparam logic [4:0] funct_fsgnj   = 5'b00100;
  localparam logic [4:0] funct_fmv_f2i = 5'b11100;
  localparam logic [4:0] funct_fmv_i2f = 5'b11110;

  localparam logic [1:0] fmt_double = 2'b01;

  localparam logic [CSR_ADDR_W-1:0] csr_fflags = 12'h001;
  localparam logic [CSR_ADDR_W-1:0] csr_frm    = 12'h002;
  localparam logic [CSR_ADDR_W-1:0] csr_fcsr   = 12'h003;

  typedef enum logic [2:0] {
    op_none,
    op_fsgnj,
    op_fsgnjn,
    op_fsgnjx,
    op_fmv_f2i,
    op_fmv_i2f
  } fpu_op_t;

  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] data;  // Integer operand for fmv.d.x
  } fpu_issue_t;

  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    fpu_op_t               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rden1;
    logic                  rden2;
    logic                  fwren;
    logic                  xwren;
    logic [XLEN-1:0]       xdata;
  } fpu_decoded_t;

  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    fpu_op_t               op;
    logic [REG_ADDR_W-1:0] rd;
    logic                  fwren;
    logic                  xwren;
    logic [XLEN-1:0]       xdata;
    logic [FLEN-1:0]       src1;
    logic [FLEN-1:0]       src2;
  } fpu_operands_t;

  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd;
    logic                  fwren;
    logic                  xwren;
    logic [FLEN-1:0]       data;
  } fpu_wb_t;

  typedef struct packed {
    logic                  rden;
    logic                  wren;
    logic [CSR_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
  } fpu_csr_req_t;

endpackage

// ==== hdl/fpu_decode.sv ====
`timescale 1ns/1ps

module fpu_decode (
  input  logic                  clock,
  input  logic                  reset,
  input  fpu_pkg::fpu_issue_t   issue_i,
  output fpu_pkg::fpu_decoded_t dec_o
);
  import fpu_pkg::*;

  logic [6:0]   opcode;
  logic [6:0]   funct7;
  logic [2:0]   funct3;
  logic [1:0]   fmt;
  logic         legal;
  fpu_decoded_t dec_d;

  assign opcode = issue_i.instr[6:0];
  assign funct3 = issue_i.instr[14:12];
  assign funct7 = issue_i.instr[31:25];
  assign fmt    = issue_i.instr[26:25];

  always_comb begin
    dec_d       = '0;
    dec_d.rd    = issue_i.instr[11:7];
    dec_d.rs1   = issue_i.instr[19:15];
    dec_d.rs2   = issue_i.instr[24:20];
    dec_d.xdata = issue_i.data;
    dec_d.op    = op_none;
    legal       = 1'b0;

    if (opcode == opcode_fp && fmt == fmt_double) begin
      case (funct7[6:2])
        funct_fsgnj: begin
          legal       = (funct3 <= 3'd2);
          dec_d.rden1 = 1'b1;
          dec_d.rden2 = 1'b1;
          dec_d.fwren = 1'b1;
          case (funct3)
            3'd0:    dec_d.op = op_fsgnj;
            3'd1:    dec_d.op = op_fsgnjn;
            default: dec_d.op = op_fsgnjx;
          endcase
        end
        funct_fmv_f2i: begin
          legal       = (funct3 == 3'd0);  // funct3 1 is fclass
          dec_d.rden1 = 1'b1;
          dec_d.xwren = 1'b1;
          dec_d.op    = op_fmv_f2i;
        end
        funct_fmv_i2f: begin
          legal       = (funct3 == 3'd0);
          dec_d.fwren = 1'b1;
          dec_d.op    = op_fmv_i2f;
        end
        default: legal = 1'b0;
      endcase
    end

    // Illegal or empty slots touch no register
    if (!legal || !issue_i.valid) begin
      dec_d.op    = op_none;
      dec_d.rden1 = 1'b0;
      dec_d.rden2 = 1'b0;
      dec_d.fwren = 1'b0;
      dec_d.xwren = 1'b0;
    end
    dec_d.valid   = issue_i.valid;
    dec_d.illegal = issue_i.valid && !legal;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= dec_d.valid;
    end
  end

  always_ff @(posedge clock) begin
    dec_o.illegal <= dec_d.illegal;
    dec_o.op      <= dec_d.op;
    dec_o.rd      <= dec_d.rd;
    dec_o.rs1     <= dec_d.rs1;
    dec_o.rs2     <= dec_d.rs2;
    dec_o.rden1   <= dec_d.rden1;
    dec_o.rden2   <= dec_d.rden2;
    dec_o.fwren   <= dec_d.fwren;
    dec_o.xwren   <= dec_d.xwren;
    dec_o.xdata   <= dec_d.xdata;
  end

endmodule

// ==== hdl/fpu_register.sv ====
`timescale 1ns/1ps

module fpu_register (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [fpu_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [fpu_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [fpu_pkg::FLEN-1:0]       rdata1_o,
  output logic [fpu_pkg::FLEN-1:0]       rdata2_o,
  input  fpu_pkg::fpu_wb_t               wb_i
);
  import fpu_pkg::*;

  logic [FLEN-1:0] regs [NUM_FREGS];
  logic            wren;

  assign wren = wb_i.valid && wb_i.fwren && !wb_i.illegal;

  always_ff @(posedge clock) begin
    if (!reset) begin
      regs <= '{default: '0};
    end else if (wren) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rdata1_o = regs[raddr1_i];  // Asynchronous read
  assign rdata2_o = regs[raddr2_i];

endmodule

// ==== hdl/fpu_operand.sv ====
`timescale 1ns/1ps

module fpu_operand (
  input  logic                           clock,
  input  logic                           reset,
  input  fpu_pkg::fpu_decoded_t          dec_i,
  input  logic [fpu_pkg::FLEN-1:0]       rdata1_i,
  input  logic [fpu_pkg::FLEN-1:0]       rdata2_i,
  output logic [fpu_pkg::REG_ADDR_W-1:0] raddr1_o,
  output logic [fpu_pkg::REG_ADDR_W-1:0] raddr2_o,
  input  fpu_pkg::fpu_wb_t               fwd_ex_i,
  input  fpu_pkg::fpu_wb_t               wb_i,
  output fpu_pkg::fpu_operands_t         ops_o
);
  import fpu_pkg::*;

  logic [FLEN-1:0] src1;
  logic [FLEN-1:0] src2;

  // Newest pending write wins over older ones
  function automatic logic [FLEN-1:0] pick_source(
    input logic                  rden,
    input logic [REG_ADDR_W-1:0] addr,
    input logic [FLEN-1:0]       rdata,
    input fpu_wb_t               ex,
    input fpu_wb_t               wb
  );
    logic [FLEN-1:0] res;
    res = '0;
    if (rden) begin
      res = rdata;
      if (wb.valid && wb.fwren && !wb.illegal && wb.rd == addr) begin
        res = wb.data;
      end
      if (ex.valid && ex.fwren && !ex.illegal && ex.rd == addr) begin
        res = ex.data;
      end
    end
    return res;
  endfunction

  assign raddr1_o = dec_i.rs1;
  assign raddr2_o = dec_i.rs2;

  assign src1 = pick_source(dec_i.rden1, dec_i.rs1, rdata1_i, fwd_ex_i, wb_i);
  assign src2 = pick_source(dec_i.rden2, dec_i.rs2, rdata2_i, fwd_ex_i, wb_i);

  always_ff @(posedge clock) begin
    if (!reset) begin
      ops_o.valid <= 1'b0;
    end else begin
      ops_o.valid <= dec_i.valid;
    end
  end

  always_ff @(posedge clock) begin
    ops_o.illegal <= dec_i.illegal;
    ops_o.op      <= dec_i.op;
    ops_o.rd      <= dec_i.rd;
    ops_o.fwren   <= dec_i.fwren;
    ops_o.xwren   <= dec_i.xwren;
    ops_o.xdata   <= dec_i.xdata;
    ops_o.src1    <= src1;
    ops_o.src2    <= src2;
  end

endmodule

// ==== hdl/fpu_execute.sv ====
`timescale 1ns/1ps

module fpu_execute (
  input  logic                   clock,
  input  logic                   reset,
  input  fpu_pkg::fpu_operands_t ops_i,
  output fpu_pkg::fpu_wb_t       fwd_ex_o,
  output fpu_pkg::fpu_wb_t       wb_o
);
  import fpu_pkg::*;

  logic            sign1;
  logic            sign2;
  logic [FLEN-2:0] mag1;
  logic [FLEN-1:0] result;

  assign sign1 = ops_i.src1[FLEN-1];
  assign sign2 = ops_i.src2[FLEN-1];
  assign mag1  = ops_i.src1[FLEN-2:0];

  always_comb begin
    case (ops_i.op)
      op_fsgnj:   result = {sign2, mag1};
      op_fsgnjn:  result = {~sign2, mag1};
      op_fsgnjx:  result = {sign1 ^ sign2, mag1};
      op_fmv_f2i: result = ops_i.src1;  // Raw bits to integer side
      op_fmv_i2f: result = ops_i.xdata;
      default:    result = '0;
    endcase
  end

  always_comb begin
    fwd_ex_o.valid   = ops_i.valid;
    fwd_ex_o.illegal = ops_i.illegal;
    fwd_ex_o.rd      = ops_i.rd;
    fwd_ex_o.fwren   = ops_i.fwren;
    fwd_ex_o.xwren   = ops_i.xwren;
    fwd_ex_o.data    = result;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wb_o.valid <= 1'b0;
    end else begin
      wb_o.valid <= fwd_ex_o.valid;
    end
  end

  always_ff @(posedge clock) begin
    wb_o.illegal <= fwd_ex_o.illegal;
    wb_o.rd      <= fwd_ex_o.rd;
    wb_o.fwren   <= fwd_ex_o.fwren;
    wb_o.xwren   <= fwd_ex_o.xwren;
    wb_o.data    <= fwd_ex_o.data;
  end

endmodule

// ==== hdl/fpu_csr.sv ====
`timescale 1ns/1ps

module fpu_csr (
  input  logic                      clock,
  input  logic                      reset,
  input  fpu_pkg::fpu_csr_req_t     csr_req_i,
  output logic [31:0]               csr_rdata_o,
  output logic                      csr_ready_o,
  output logic [fpu_pkg::FRM_W-1:0] frm_o
);
  import fpu_pkg::*;

  logic [FRM_W-1:0]    frm;
  logic [FFLAGS_W-1:0] fflags;

  always_comb begin
    csr_rdata_o = '0;
    csr_ready_o = 1'b0;
    if (csr_req_i.rden) begin
      case (csr_req_i.addr)
        csr_fflags: begin
          csr_rdata_o = {{(32 - FFLAGS_W){1'b0}}, fflags};
          csr_ready_o = 1'b1;
        end
        csr_frm: begin
          csr_rdata_o = {{(32 - FRM_W){1'b0}}, frm};
          csr_ready_o = 1'b1;
        end
        csr_fcsr: begin
          csr_rdata_o = {{(32 - FRM_W - FFLAGS_W){1'b0}}, frm, fflags};
          csr_ready_o = 1'b1;
        end
        default: ;  // Unknown address reads zero
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      frm    <= '0;
      fflags <= '0;
    end else if (csr_req_i.wren) begin
      case (csr_req_i.addr)
        csr_fflags: fflags <= csr_req_i.wdata[FFLAGS_W-1:0];
        csr_frm:    frm    <= csr_req_i.wdata[FRM_W-1:0];
        csr_fcsr: begin
          fflags <= csr_req_i.wdata[FFLAGS_W-1:0];
          frm    <= csr_req_i.wdata[FFLAGS_W +: FRM_W];  // Bits 7:5
        end
        default: ;
      endcase
    end
  end

  assign frm_o = frm;

endmodule

// ==== hdl/fpu_top.sv ====
`timescale 1ns/1ps

module fpu_top (
  input  logic                      clock,
  input  logic                      reset,
  input  fpu_pkg::fpu_issue_t       issue_i,
  output fpu_pkg::fpu_wb_t          result_o,
  input  fpu_pkg::fpu_csr_req_t     csr_req_i,
  output logic [31:0]               csr_rdata_o,
  output logic                      csr_ready_o,
  output logic [fpu_pkg::FRM_W-1:0] frm_o
);
  import fpu_pkg::*;

  fpu_decoded_t          dec;
  fpu_operands_t         ops;
  fpu_wb_t               fwd_ex;
  fpu_wb_t               wb;
  logic [REG_ADDR_W-1:0] raddr1;
  logic [REG_ADDR_W-1:0] raddr2;
  logic [FLEN-1:0]       rdata1;
  logic [FLEN-1:0]       rdata2;

  fpu_decode u_decode (
    .clock   (clock),
    .reset   (reset),
    .issue_i (issue_i),
    .dec_o   (dec)
  );

  fpu_operand u_operand (
    .clock    (clock),
    .reset    (reset),
    .dec_i    (dec),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .raddr1_o (raddr1),
    .raddr2_o (raddr2),
    .fwd_ex_i (fwd_ex),
    .wb_i     (wb),
    .ops_o    (ops)
  );

  fpu_register u_register (
    .clock    (clock),
    .reset    (reset),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb)
  );

  fpu_execute u_execute (
    .clock    (clock),
    .reset    (reset),
    .ops_i    (ops),
    .fwd_ex_o (fwd_ex),
    .wb_o     (wb)
  );

  fpu_csr u_csr (
    .clock       (clock),
    .reset       (reset),
    .csr_req_i   (csr_req_i),
    .csr_rdata_o (csr_rdata_o),
    .csr_ready_o (csr_ready_o),
    .frm_o       (frm_o)
  );

  assign result_o = wb;  // Writeback bundle doubles as the result port

endmodule

// ==== verification/fpu_assert.sv ====
`timescale 1ns/1ps

module fpu_assert (
  input logic                  clock,
  input logic                  reset,
  input fpu_pkg::fpu_issue_t   issue_i,
  input fpu_pkg::fpu_wb_t      result_i,
  input fpu_pkg::fpu_csr_req_t csr_req_i,
  input logic                  csr_ready_i
);

  // Decode, operand and execute each add one cycle
  result_latency: assert property (
    @(posedge clock) disable iff (!reset)
    result_i.valid == $past(issue_i.valid, 3)
  ) else $error("result valid is not exactly three cycles after issue valid");

  reset_quiet: assert property (
    @(posedge clock) !reset |=> !result_i.valid && !csr_ready_i
  ) else $error("result valid or CSR ready high during or right after reset");

  ready_with_read: assert property (
    @(posedge clock) csr_ready_i |-> csr_req_i.rden
  ) else $error("CSR ready high without a read request");

endmodule

// ==== verification/fpu_tb.sv ====
`timescale 1ns/1ps

module fpu_tb;
  import fpu_pkg::*;

  localparam int period      = 20;
  localparam int num_sgnj    = 40;
  localparam int dep_reps    = 8;
  localparam int num_issues  = 4 + 2 * NUM_FREGS + num_sgnj + dep_reps * 9 + 10;
  localparam int num_csr_ops = 24;
  localparam int watchdog_ns = (16 + num_issues + num_csr_ops + 40) * period;

  logic             clock;
  logic             reset;
  fpu_issue_t       issue;
  fpu_wb_t          result;
  fpu_csr_req_t     csr_req;
  logic [31:0]      csr_rdata;
  logic             csr_ready;
  logic [FRM_W-1:0] frm;
  logic [FLEN-1:0]  model_regs [NUM_FREGS];
  logic [2:0]       model_frm;
  logic [4:0]       model_fflags;
  fpu_wb_t          exp_q [$];
  logic [31:0]      lcg_state = 32'hcb829b91;
  int               n_issued = 0;
  int               n_checked = 0;

  fpu_top dut (
    .clock       (clock),
    .reset       (reset),
    .issue_i     (issue),
    .result_o    (result),
    .csr_req_i   (csr_req),
    .csr_rdata_o (csr_rdata),
    .csr_ready_o (csr_ready),
    .frm_o       (frm)
  );

  bind fpu_top fpu_assert u_assert (
    .clock       (clock),
    .reset       (reset),
    .issue_i     (issue_i),
    .result_i    (result_o),
    .csr_req_i   (csr_req_i),
    .csr_ready_i (csr_ready_o)
  );

  always #(period / 2) clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  function automatic logic [31:0] fp_instr(input logic [4:0] f5, input logic [1:0] fmt,
      input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f5, fmt, rs2, rs1, f3, rd, 7'b1010011};
  endfunction

  // Expected writeback of one instruction, applied in program order
  function automatic fpu_wb_t ref_model(input logic [31:0] instr, input logic [XLEN-1:0] xdata);
    fpu_wb_t         expected;
    logic [FLEN-1:0] a;
    logic [FLEN-1:0] b;
    expected         = '0;
    expected.valid   = 1'b1;
    expected.illegal = 1'b1;
    expected.rd      = instr[11:7];
    a = model_regs[instr[19:15]];
    b = model_regs[instr[24:20]];
    if (instr[6:0] == 7'b1010011 && instr[26:25] == 2'b01) begin
      if (instr[31:27] == 5'b00100 && instr[14:12] <= 3'd2) begin
        expected.illegal = 1'b0;
        expected.fwren   = 1'b1;
        case (instr[14:12])
          3'd0:    expected.data = {b[63], a[62:0]};
          3'd1:    expected.data = {~b[63], a[62:0]};
          default: expected.data = {a[63] ^ b[63], a[62:0]};
        endcase
      end else if (instr[31:27] == 5'b11100 && instr[14:12] == 3'd0) begin
        expected.illegal = 1'b0;
        expected.xwren   = 1'b1;
        expected.data    = a;
      end else if (instr[31:27] == 5'b11110 && instr[14:12] == 3'd0) begin
        expected.illegal = 1'b0;
        expected.fwren   = 1'b1;
        expected.data    = xdata;
      end
    end
    if (expected.fwren) model_regs[expected.rd] = expected.data;
    return expected;
  endfunction

  // Ready bit on top of the read data
  function automatic logic [32:0] csr_expect(input logic [11:0] addr);
    case (addr)
      12'h001: return {1'b1, 27'b0, model_fflags};
      12'h002: return {1'b1, 29'b0, model_frm};
      12'h003: return {1'b1, 24'b0, model_frm, model_fflags};
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [79:0] got, input logic [79:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic issue_op(input logic [31:0] instr, input logic [XLEN-1:0] xdata);
    @(posedge clock);
    issue.valid <= 1'b1;
    issue.instr <= instr;
    issue.data  <= xdata;
    exp_q.push_back(ref_model(instr, xdata));
    n_issued++;
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] wdata);
    @(posedge clock);
    csr_req <= '{rden: 1'b0, wren: 1'b1, addr: addr, wdata: wdata};
    case (addr)
      12'h001: model_fflags = wdata[4:0];
      12'h002: model_frm = wdata[2:0];
      12'h003: {model_frm, model_fflags} = wdata[7:0];
      default: ;
    endcase
  endtask

  task automatic csr_read_check(input logic [11:0] addr);
    logic [32:0] expected;
    @(posedge clock);
    csr_req <= '{rden: 1'b1, wren: 1'b0, addr: addr, wdata: 32'h0};
    @(negedge clock);
    expected = csr_expect(addr);
    check_value("csr_rdata_o", csr_rdata, expected[31:0]);
    check_value("csr_ready_o", csr_ready, expected[32]);
    check_value("frm_o", frm, model_frm);
  endtask

  always @(negedge clock) begin
    fpu_wb_t expected;
    if (reset && result.valid) begin
      assert (exp_q.size() != 0) else begin
        $display("A result came out with no instruction pending at %0t ns", $time);
        $display("test failed");
        $fatal(1);
      end
      expected = exp_q.pop_front();
      check_value("result_o", result, expected);
      n_checked++;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("test failed");
    $fatal(1);
  end

  initial begin
    logic [31:0] r;
    logic [31:0] instr;
    int          ill_rd [5];
    clock        = 1'b0;
    reset        = 1'b0;
    issue        = '0;
    csr_req      = '0;
    model_regs   = '{default: '0};
    model_frm    = '0;
    model_fflags = '0;
    ill_rd       = '{3, 6, 7, 8, 9};
    repeat (16) @(posedge clock);
    reset <= 1'b1;

    for (int a = 1; a <= 3; a++) csr_read_check(12'(a));
    csr_write(12'h002, 32'h5);
    csr_read_check(12'h002);
    csr_read_check(12'h003);
    csr_write(12'h001, 32'hffff_ffea);  // Upper bits ignored
    csr_read_check(12'h001);
    csr_read_check(12'h003);
    csr_write(12'h003, 32'h0000_00d3);
    for (int a = 1; a <= 3; a++) csr_read_check(12'(a));
    csr_read_check(12'h004);
    csr_read_check(12'h7ff);
    repeat (4) begin
      r = lcg_next();
      csr_write(12'd1 + 12'(r[29:28] % 3), lcg_next());
      csr_read_check(12'h003);
    end
    @(posedge clock);
    csr_req <= '0;

    for (int i = 0; i < 4; i++) begin
      issue_op(fp_instr(5'b11100, 2'b01, 3'd0, 5'd1, 5'(i * 9), 5'd0), '0);
    end
    for (int i = 0; i < NUM_FREGS; i++) begin
      issue_op(fp_instr(5'b11110, 2'b01, 3'd0, 5'(i), 5'd0, 5'd0), rand64());
    end
    for (int i = 0; i < NUM_FREGS; i++) begin
      issue_op(fp_instr(5'b11100, 2'b01, 3'd0, 5'd2, 5'(i), 5'd0), '0);
    end
    repeat (num_sgnj) begin
      r = lcg_next();
      issue_op(fp_instr(5'b00100, 2'b01, 3'(r[31:24] % 3), r[20:16], r[15:11], r[10:6]), '0);
    end
    // Producer to consumer distance d covers both forwarding paths and the register file
    for (int d = 1; d <= 3; d++) begin
      repeat (dep_reps) begin
        r = lcg_next();
        issue_op(fp_instr(5'b11110, 2'b01, 3'd0, r[20:16], 5'd0, 5'd0), rand64());
        repeat (d - 1) issue_op(fp_instr(5'b11100, 2'b01, 3'd0, r[10:6], r[15:11], 5'd0), '0);
        issue_op(fp_instr(5'b00100, 2'b01, 3'(r[31:24] % 3), r[25:21], r[20:16], r[20:16]), '0);
      end
    end
    issue_op(fp_instr(5'b00100, 2'b00, 3'd0, 5'd3, 5'd4, 5'd5), '0);  // Single precision
    issue_op(fp_instr(5'b00100, 2'b01, 3'd3, 5'd6, 5'd4, 5'd5), '0);
    issue_op(fp_instr(5'b11100, 2'b01, 3'd1, 5'd7, 5'd4, 5'd0), '0);  // fclass
    instr      = fp_instr(5'b00100, 2'b01, 3'd0, 5'd8, 5'd4, 5'd5);
    instr[6:0] = 7'b0000011;
    issue_op(instr, '0);
    issue_op(fp_instr(5'b11110, 2'b00, 3'd0, 5'd9, 5'd0, 5'd0), rand64());
    for (int i = 0; i < 5; i++) begin
      issue_op(fp_instr(5'b11100, 2'b01, 3'd0, 5'd1, 5'(ill_rd[i]), 5'd0), '0);
    end
    @(posedge clock);
    issue.valid <= 1'b0;

    repeat (6) @(negedge clock);  // Last result is due three edges after its issue
    if (exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Only %0d results came out of %0d issued", n_checked, n_issued);
      $display("test failed");
      $fatal(1);
    end
  end

endmodule

// ==== list.f ====
hdl/fpu_pkg.sv
hdl/fpu_decode.sv
hdl/fpu_register.sv
hdl/fpu_operand.sv
hdl/fpu_execute.sv
hdl/fpu_csr.sv
hdl/fpu_top.sv
verification/fpu_assert.sv
verification/fpu_tb.sv

// ==== Bender.yml ====
package:
  name: fpu_front

sources:
  - hdl/fpu_pkg.sv
  - hdl/fpu_decode.sv
  - hdl/fpu_register.sv
  - hdl/fpu_operand.sv
  - hdl/fpu_execute.sv
  - hdl/fpu_csr.sv
  - hdl/fpu_top.sv
  - target: simulation
    files:
      - verification/fpu_assert.sv
      - verification/fpu_tb.sv
